// File: compile.f
hdl/rvCorePkg.sv
hdl/rvRegFile.sv
hdl/rvDecode.sv
hdl/rvExecute.sv
hdl/rvResult.sv
hdl/rvCore.sv
sim/rvCoreTb.sv

// File: hdl/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
  parameter int DataWords = 64
) (
  input  logic              clk,
  input  logic              arstN,
  output logic              fetchReq,
  output logic [31:0]       fetchPc,
  input  logic              fetchAck,
  input  logic [31:0]       fetchInstr,
  output rvCorePkg::retireT retire
);

  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [31:0]         rs1Value;
  logic [31:0]         rs2Value;
  logic                exMemRead;
  logic [4:0]          exRd;
  logic                regWrite;
  logic [4:0]          regRd;
  logic [31:0]         regData;
  rvCorePkg::decodedT  decoded;
  rvCorePkg::executedT executed;
  rvCorePkg::forwardT  forward;

  rvRegFile registerFile (
    .clk(clk),
    .arstN(arstN),
    .rs1(rs1),
    .rs2(rs2),
    .rs1Value(rs1Value),
    .rs2Value(rs2Value),
    .writeEnable(regWrite),
    .writeRd(regRd),
    .writeData(regData)
  );

  rvDecode decodeStage (
    .clk(clk),
    .arstN(arstN),
    .fetchReq(fetchReq),
    .fetchPc(fetchPc),
    .fetchAck(fetchAck),
    .fetchInstr(fetchInstr),
    .rs1(rs1),
    .rs2(rs2),
    .rs1Value(rs1Value),
    .rs2Value(rs2Value),
    .exMemRead(exMemRead),
    .exRd(exRd),
    .decoded(decoded)
  );

  rvExecute executeStage (
    .clk(clk),
    .arstN(arstN),
    .decoded(decoded),
    .forward(forward),
    .exMemRead(exMemRead),
    .exRd(exRd),
    .executed(executed)
  );

  rvResult #(
    .DataWords(DataWords)
  ) resultStage (
    .clk(clk),
    .arstN(arstN),
    .executed(executed),
    .forward(forward),
    .regWrite(regWrite),
    .regRd(regRd),
    .regData(regData),
    .retire(retire)
  );

endmodule

`default_nettype wire

// File: hdl/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

  // major opcodes that the core executes, anything else is a no-op
  typedef enum logic [6:0] {
    opReg   = 7'b0110011,
    opImm   = 7'b0010011,
    opLoad  = 7'b0000011,
    opStore = 7'b0100011
  } opcodeE;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluSll,
    aluSrl
  } aluOpE;

  typedef enum logic [1:0] {
    fetchIdle,
    fetchWaitAck,
    fetchWaitRelease
  } fetchStateE;

  // decode to execute
  typedef struct packed {
    logic        valid;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] rs1Value;
    logic [31:0] rs2Value;
    logic [31:0] immediate;
    aluOpE       aluOp;
    logic        aluSrc;
    logic        memRead;
    logic        memWrite;
    logic        regWrite;
  } decodedT;

  // execute to result
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] aluResult;
    logic [31:0] storeData;
    logic        memRead;
    logic        memWrite;
    logic        regWrite;
  } executedT;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } retireT;

  // result stage back to execute
  typedef struct packed {
    logic        memRegWrite;
    logic [4:0]  memRd;
    logic [31:0] memAluResult;
    logic        wbRegWrite;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
  } forwardT;

endpackage

`default_nettype wire

// File: hdl/rvDecode.sv
`timescale 1ns/1ps
`default_nettype none

module rvDecode (
  input  logic                clk,
  input  logic                arstN,
  output logic                fetchReq,
  output logic [31:0]         fetchPc,
  input  logic                fetchAck,
  input  logic [31:0]         fetchInstr,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  input  logic [31:0]         rs1Value,
  input  logic [31:0]         rs2Value,
  input  logic                exMemRead,
  input  logic [4:0]          exRd,
  output rvCorePkg::decodedT  decoded
);

  rvCorePkg::fetchStateE fetchState;
  rvCorePkg::opcodeE     opcode;
  rvCorePkg::aluOpE      aluOp;

  logic        bufValid;
  logic [31:0] bufInstr;
  logic        bufDrain;
  logic        bufFree;
  logic        capture;
  logic        ifIdValid;
  logic [31:0] ifIdInstr;
  logic        stall;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  rd;
  logic [31:0] iImm;
  logic [31:0] sImm;
  logic [31:0] immediate;
  logic        aluSrc;
  logic        ctlMemRead;
  logic        ctlMemWrite;
  logic        writesRd;

  assign fetchReq = (fetchState == rvCorePkg::fetchWaitAck);
  assign capture  = fetchReq && fetchAck;

  // load in execute feeding this instruction
  assign stall = ifIdValid && exMemRead && exRd != 5'd0 && (exRd == rs1 || exRd == rs2);

  assign bufDrain = bufValid && !stall;
  assign bufFree  = !bufValid || bufDrain;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fetchState <= rvCorePkg::fetchIdle;
      fetchPc    <= '0;
    end else begin
      case (fetchState)
        rvCorePkg::fetchIdle: begin
          if (bufFree && !fetchAck) fetchState <= rvCorePkg::fetchWaitAck;
        end
        rvCorePkg::fetchWaitAck: begin
          if (fetchAck) begin
            fetchState <= rvCorePkg::fetchWaitRelease;
            fetchPc    <= fetchPc + 32'd4;
          end
        end
        rvCorePkg::fetchWaitRelease: begin
          // ack low again, next request may go out at once
          if (!fetchAck) begin
            fetchState <= bufFree ? rvCorePkg::fetchWaitAck : rvCorePkg::fetchIdle;
          end
        end
        default: fetchState <= rvCorePkg::fetchIdle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      bufValid  <= 1'b0;
      ifIdValid <= 1'b0;
    end else begin
      if (capture) bufValid <= 1'b1;
      else if (bufDrain) bufValid <= 1'b0;
      if (!stall) ifIdValid <= bufValid;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) bufInstr <= fetchInstr;
    if (!stall) ifIdInstr <= bufInstr;
  end

  assign opcode = rvCorePkg::opcodeE'(ifIdInstr[6:0]);
  assign funct3 = ifIdInstr[14:12];
  assign funct7 = ifIdInstr[31:25];
  assign rd     = ifIdInstr[11:7];
  assign rs1    = ifIdInstr[19:15];
  assign rs2    = ifIdInstr[24:20];
  assign iImm   = {{20{ifIdInstr[31]}}, ifIdInstr[31:20]};
  assign sImm   = {{20{ifIdInstr[31]}}, ifIdInstr[31:25], ifIdInstr[11:7]};

  always_comb begin
    aluOp       = rvCorePkg::aluAdd;
    aluSrc      = 1'b0;
    ctlMemRead  = 1'b0;
    ctlMemWrite = 1'b0;
    writesRd    = 1'b0;
    immediate   = iImm;
    case (opcode)
      rvCorePkg::opReg: begin
        if (funct7 == 7'd0 || (funct7 == 7'b0100000 && funct3 == 3'b000)) begin
          writesRd = 1'b1;
          case (funct3)
            3'b000:  aluOp = funct7[5] ? rvCorePkg::aluSub : rvCorePkg::aluAdd;
            3'b001:  aluOp = rvCorePkg::aluSll;
            3'b010:  aluOp = rvCorePkg::aluSlt;
            3'b100:  aluOp = rvCorePkg::aluXor;
            3'b101:  aluOp = rvCorePkg::aluSrl;
            3'b110:  aluOp = rvCorePkg::aluOr;
            3'b111:  aluOp = rvCorePkg::aluAnd;
            default: writesRd = 1'b0;
          endcase
        end
      end
      rvCorePkg::opImm: begin
        aluSrc   = 1'b1;
        writesRd = 1'b1;
        case (funct3)
          3'b000:  aluOp = rvCorePkg::aluAdd;
          3'b010:  aluOp = rvCorePkg::aluSlt;
          3'b100:  aluOp = rvCorePkg::aluXor;
          3'b110:  aluOp = rvCorePkg::aluOr;
          3'b111:  aluOp = rvCorePkg::aluAnd;
          default: writesRd = 1'b0;
        endcase
      end
      rvCorePkg::opLoad: begin
        // word accesses only
        if (funct3 == 3'b010) begin
          aluSrc     = 1'b1;
          ctlMemRead = 1'b1;
          writesRd   = 1'b1;
        end
      end
      rvCorePkg::opStore: begin
        if (funct3 == 3'b010) begin
          aluSrc      = 1'b1;
          ctlMemWrite = 1'b1;
          immediate   = sImm;
        end
      end
      default: ;
    endcase
  end

  // a stall turns the outgoing slot into a bubble
  always_comb begin
    decoded.valid     = ifIdValid && !stall;
    decoded.rs1       = rs1;
    decoded.rs2       = rs2;
    decoded.rd        = rd;
    decoded.rs1Value  = rs1Value;
    decoded.rs2Value  = rs2Value;
    decoded.immediate = immediate;
    decoded.aluOp     = aluOp;
    decoded.aluSrc    = aluSrc;
    decoded.memRead   = decoded.valid && ctlMemRead;
    decoded.memWrite  = decoded.valid && ctlMemWrite;
    decoded.regWrite  = decoded.valid && writesRd && rd != 5'd0;
  end

  assert property (@(posedge clk) disable iff (!arstN)
    fetchReq && !fetchAck |=> fetchReq);

  assert property (@(posedge clk) disable iff (!arstN)
    $rose(fetchReq) |-> !$past(fetchAck));

endmodule

`default_nettype wire

// File: hdl/rvExecute.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecute (
  input  logic                clk,
  input  logic                arstN,
  input  rvCorePkg::decodedT  decoded,
  input  rvCorePkg::forwardT  forward,
  output logic                exMemRead,
  output logic [4:0]          exRd,
  output rvCorePkg::executedT executed
);

  rvCorePkg::decodedT idEx;

  logic [31:0] opA;
  logic [31:0] rs2Fwd;
  logic [31:0] opB;
  logic [31:0] aluResult;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idEx <= '0;
    end else begin
      idEx <= decoded;
    end
  end

  // memory stage first, then writeback, then the register value
  function automatic logic [31:0] forwardValue(
    input logic [4:0]         idx,
    input logic [31:0]        regValue,
    input rvCorePkg::forwardT fwd
  );
    if (idx == 5'd0) return regValue;
    if (fwd.memRegWrite && fwd.memRd == idx) return fwd.memAluResult;
    if (fwd.wbRegWrite && fwd.wbRd == idx) return fwd.wbData;
    return regValue;
  endfunction

  assign opA    = forwardValue(idEx.rs1, idEx.rs1Value, forward);
  assign rs2Fwd = forwardValue(idEx.rs2, idEx.rs2Value, forward);
  assign opB    = idEx.aluSrc ? idEx.immediate : rs2Fwd;

  always_comb begin
    case (idEx.aluOp)
      rvCorePkg::aluAdd: aluResult = opA + opB;
      rvCorePkg::aluSub: aluResult = opA - opB;
      rvCorePkg::aluAnd: aluResult = opA & opB;
      rvCorePkg::aluOr:  aluResult = opA | opB;
      rvCorePkg::aluXor: aluResult = opA ^ opB;
      rvCorePkg::aluSlt: aluResult = {31'd0, $signed(opA) < $signed(opB)};
      rvCorePkg::aluSll: aluResult = opA << opB[4:0];
      rvCorePkg::aluSrl: aluResult = opA >> opB[4:0];
      default:           aluResult = '0;
    endcase
  end

  // seen by decode for the load-use check
  assign exMemRead = idEx.memRead;
  assign exRd      = idEx.rd;

  always_comb begin
    executed.valid     = idEx.valid;
    executed.rd        = idEx.rd;
    executed.aluResult = aluResult;
    executed.storeData = rs2Fwd;
    executed.memRead   = idEx.memRead;
    executed.memWrite  = idEx.memWrite;
    executed.regWrite  = idEx.regWrite;
  end

endmodule

`default_nettype wire

// File: hdl/rvRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module rvRegFile (
  input  logic        clk,
  input  logic        arstN,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1Value,
  output logic [31:0] rs2Value,
  input  logic        writeEnable,
  input  logic [4:0]  writeRd,
  input  logic [31:0] writeData
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  function automatic logic [31:0] readPort(input logic [4:0] idx);
    if (idx == 5'd0) return 32'd0;
    // same-cycle write shows through
    if (writeEnable && writeRd == idx) return writeData;
    return regs[idx];
  endfunction

  always_comb rs1Value = readPort(rs1);
  always_comb rs2Value = readPort(rs2);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && writeRd != 5'd0) begin
      regs[writeRd] <= writeData;
    end
  end

  // decode must already have dropped rd == 0 writes
  assert property (@(posedge clk) disable iff (!arstN) writeEnable |-> writeRd != 5'd0);

endmodule

`default_nettype wire

// File: hdl/rvResult.sv
`timescale 1ns/1ps
`default_nettype none

module rvResult #(
  parameter int DataWords = 64
) (
  input  logic                clk,
  input  logic                arstN,
  input  rvCorePkg::executedT executed,
  output rvCorePkg::forwardT  forward,
  output logic                regWrite,
  output logic [4:0]          regRd,
  output logic [31:0]         regData,
  output rvCorePkg::retireT   retire
);

  localparam int AddrBits = $clog2(DataWords);

  rvCorePkg::executedT exMem;

  logic [31:0]         dataMem [DataWords];
  logic [AddrBits-1:0] memAddr;
  logic [31:0]         loadData;
  logic                wbRegWrite;
  logic                wbMemRead;
  logic [4:0]          wbRd;
  logic [31:0]         wbAluResult;
  logic [31:0]         wbLoadData;
  logic [31:0]         wbData;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMem <= '0;
    end else begin
      exMem <= executed;
    end
  end

  // word address, wraps at DataWords
  assign memAddr  = exMem.aluResult[AddrBits+1:2];
  assign loadData = dataMem[memAddr];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < DataWords; i++) begin
        dataMem[i] <= '0;
      end
    end else if (exMem.valid && exMem.memWrite) begin
      dataMem[memAddr] <= exMem.storeData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbRegWrite <= 1'b0;
      wbMemRead  <= 1'b0;
      wbRd       <= '0;
    end else begin
      wbRegWrite <= exMem.valid && exMem.regWrite;
      wbMemRead  <= exMem.memRead;
      wbRd       <= exMem.rd;
    end
  end

  always_ff @(posedge clk) begin
    wbAluResult <= exMem.aluResult;
    wbLoadData  <= loadData;
  end

  assign wbData = wbMemRead ? wbLoadData : wbAluResult;

  always_comb begin
    forward.memRegWrite  = exMem.valid && exMem.regWrite;
    forward.memRd        = exMem.rd;
    forward.memAluResult = exMem.aluResult;
    forward.wbRegWrite   = wbRegWrite;
    forward.wbRd         = wbRd;
    forward.wbData       = wbData;
  end

  assign regWrite = wbRegWrite;
  assign regRd    = wbRd;
  assign regData  = wbData;

  // one retire per register write
  always_comb begin
    retire.valid = wbRegWrite;
    retire.rd    = wbRd;
    retire.data  = wbData;
  end

  assert property (@(posedge clk) disable iff (!arstN) retire.valid |-> retire.rd != 5'd0);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the rvCore testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Mdir "$BUILD_DIR" --top-module rvCoreTb -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/VrvCoreTb" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

// File: sim/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;

  localparam int DataWords = 64;
  localparam int ProgLength = 400;
  localparam int ResetCycles = 5;
  localparam int Seed = 21642;
  // per instruction handshake plus worst ack delay and one stall
  localparam int WatchdogCycles = ProgLength * (4 + 3 + 1) + 50;
  localparam int QuietCycles = 10;
  localparam logic [31:0] NopInstr = 32'h0000_0013;

  logic              clk = 1'b0;
  logic              arstN;
  logic              fetchReq;
  logic [31:0]       fetchPc;
  logic              fetchAck;
  logic [31:0]       fetchInstr;
  rvCorePkg::retireT retire;

  logic [31:0]       progMem [ProgLength];
  logic [31:0]       modelRegs [32];
  logic [31:0]       modelMem [DataWords];
  rvCorePkg::retireT expectQ [$];
  int                retireCount = 0;

  rvCore #(
    .DataWords(DataWords)
  ) u_dut (
    .clk(clk),
    .arstN(arstN),
    .fetchReq(fetchReq),
    .fetchPc(fetchPc),
    .fetchAck(fetchAck),
    .fetchInstr(fetchInstr),
    .retire(retire)
  );

  always #2 clk = ~clk;

  task automatic abortRun();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkRetire(input string name, input rvCorePkg::retireT expected,
                             input rvCorePkg::retireT actual);
    if (actual !== expected) begin
      $display("Error: %s expected rd=x%0d data=%h actual rd=x%0d data=%h",
               name, expected.rd, expected.data, actual.rd, actual.data);
      abortRun();
    end
  endtask

  task automatic checkFetchPc(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic compareLevel(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error: %s expected %b actual %b", name, expected, actual);
      abortRun();
    end
  endtask

  // results by funct3 as the ISA defines them
  function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b100:  return a ^ b;
      3'b101:  return a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // generates the program and runs it on the model in the same pass
  task automatic buildProgram();
    int                kind;
    int                idx;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        lastBase;
    logic [11:0]       imm;
    logic [11:0]       lastImm;
    logic [2:0]        f3;
    logic              alt;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       immExt;
    logic [31:0]       addr;
    logic [31:0]       result;
    rvCorePkg::retireT exp;
    for (int i = 0; i < 32; i++) modelRegs[i] = '0;
    for (int i = 0; i < DataWords; i++) modelMem[i] = '0;
    lastBase = 5'd0;
    lastImm = 12'd0;
    for (int n = 0; n < ProgLength; n++) begin
      kind = $urandom_range(0, 9);
      // small register window keeps dependencies close
      rd = 5'($urandom_range(0, 7));
      rs1 = 5'($urandom_range(0, 7));
      rs2 = 5'($urandom_range(0, 7));
      imm = 12'($urandom);
      // half the loads reuse the last store's base and offset
      if (kind >= 6 && kind < 8 && $urandom_range(0, 1) == 1) begin
        rs1 = lastBase;
        imm = lastImm;
      end
      a = modelRegs[rs1];
      b = modelRegs[rs2];
      immExt = {{20{imm[11]}}, imm};
      addr = a + immExt;
      idx = int'((addr >> 2) % 32'(DataWords));
      f3 = 3'($urandom_range(0, 7));
      alt = 1'b0;
      result = '0;
      if (kind < 4) begin
        // no sltu
        if (f3 == 3'b011) f3 = 3'b000;
        alt = (f3 == 3'b000) && ($urandom_range(0, 1) == 1);
        progMem[n] = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, rvCorePkg::opReg};
        result = aluModel(f3, alt, a, b);
      end else if (kind < 6) begin
        // no immediate shifts or sltiu
        if (f3 == 3'b001 || f3 == 3'b011 || f3 == 3'b101) f3 = 3'b000;
        progMem[n] = {imm, rs1, f3, rd, rvCorePkg::opImm};
        result = aluModel(f3, 1'b0, a, immExt);
      end else if (kind < 8) begin
        progMem[n] = {imm, rs1, 3'b010, rd, rvCorePkg::opLoad};
        result = modelMem[idx];
      end else begin
        progMem[n] = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvCorePkg::opStore};
        modelMem[idx] = b;
        lastBase = rs1;
        lastImm = imm;
      end
      if (kind < 8 && rd != 5'd0) begin
        modelRegs[rd] = result;
        exp.valid = 1'b1;
        exp.rd = rd;
        exp.data = result;
        expectQ.push_back(exp);
      end
    end
  endtask

  // four-phase fetch responder with a random ack delay
  initial begin
    int delay;
    int reqCount;
    fetchAck = 1'b0;
    fetchInstr = '0;
    reqCount = 0;
    wait (arstN === 1'b1);
    forever begin
      @(negedge clk);
      if (fetchReq && !fetchAck) begin
        checkFetchPc($sformatf("fetchPc request %0d", reqCount), 32'(reqCount * 4), fetchPc);
        delay = $urandom_range(0, 3);
        repeat (delay) begin
          @(negedge clk);
          compareLevel($sformatf("fetchReq held %0d", reqCount), 1'b1, fetchReq);
          checkFetchPc($sformatf("fetchPc held %0d", reqCount), 32'(reqCount * 4), fetchPc);
        end
        fetchInstr = (reqCount < ProgLength) ? progMem[reqCount] : NopInstr;
        fetchAck = 1'b1;
        reqCount++;
        // ack stays up until the request is released
        do @(negedge clk); while (fetchReq);
        fetchAck = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (arstN && retire.valid) begin
      if (expectQ.size() == 0) begin
        $display("Unexpected retire of x%0d after the last expected register write",
                 retire.rd);
        abortRun();
      end else begin
        checkRetire($sformatf("retire %0d", retireCount), expectQ.pop_front(), retire);
        retireCount++;
      end
    end
  end

  initial begin
    repeat (ResetCycles + WatchdogCycles) @(posedge clk);
    $display("Watchdog expired: retirement stalled with %0d results outstanding",
             expectQ.size());
    abortRun();
  end

  initial begin
    void'($urandom(Seed));
    arstN = 1'b0;
    buildProgram();
    repeat (ResetCycles) begin
      @(negedge clk);
      compareLevel("reset fetchReq", 1'b0, fetchReq);
      compareLevel("reset retire.valid", 1'b0, retire.valid);
    end
    arstN = 1'b1;
    while (expectQ.size() != 0) @(negedge clk);
    // no stray retires from the trailing no-ops
    repeat (QuietCycles) @(negedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
